//--- design/event_counters.sv
`timescale 1ns/1ps
`default_nettype none

module event_counters (
    input  wire                                  AXI_ACLK,
    input  wire                                  AXI_RESETN,
    input  wire                                  count_strobe,
    input  rtr_stream_pkg::verdict_t             hdr_verdict,
    input  wire                                  counter_clear,
    output logic [rtr_reg_pkg::reg_width-1:0]    wrong_mac_count,
    output logic [rtr_reg_pkg::reg_width-1:0]    non_ip_count,
    output logic [rtr_reg_pkg::reg_width-1:0]    bad_ttl_count,
    output logic [rtr_reg_pkg::reg_width-1:0]    forwarded_count
);

    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_RESETN || counter_clear) begin         // Clear beats a same-cycle event
            wrong_mac_count <= '0;
            non_ip_count    <= '0;
            bad_ttl_count   <= '0;
            forwarded_count <= '0;
        end else if (count_strobe) begin
            case (hdr_verdict)                          // Counters wrap
                rtr_stream_pkg::verdict_wrong_mac: wrong_mac_count <= wrong_mac_count + 1'b1;
                rtr_stream_pkg::verdict_non_ip:    non_ip_count    <= non_ip_count + 1'b1;
                rtr_stream_pkg::verdict_bad_ttl:   bad_ttl_count   <= bad_ttl_count + 1'b1;
                default:                           forwarded_count <= forwarded_count + 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/header_check.sv
`timescale 1ns/1ps
`default_nettype none

module header_check (
    input  wire [rtr_stream_pkg::data_width-1:0]  beat_tdata,
    input  wire [rtr_stream_pkg::tuser_width-1:0] beat_tuser,
    input  wire [47:0]                            mac_addr0,
    input  wire [47:0]                            mac_addr1,
    input  wire [47:0]                            mac_addr2,
    input  wire [47:0]                            mac_addr3,
    output rtr_stream_pkg::verdict_t              hdr_verdict,
    output logic [rtr_stream_pkg::tuser_width-1:0] fwd_tuser
);

    logic [47:0] dmac;
    logic [15:0] ethertype;
    logic [3:0]  version;
    logic [7:0]  ttl;
    logic        mac_hit;
    logic        from_cpu;
    logic [rtr_stream_pkg::port_width-1:0] src_port;

    // Field extraction
    assign dmac      = beat_tdata[rtr_stream_pkg::dmac_hi:rtr_stream_pkg::dmac_lo];
    assign ethertype = beat_tdata[rtr_stream_pkg::ethertype_hi:rtr_stream_pkg::ethertype_lo];
    assign version   = beat_tdata[rtr_stream_pkg::version_hi:rtr_stream_pkg::version_lo];
    assign ttl       = beat_tdata[rtr_stream_pkg::ttl_hi:rtr_stream_pkg::ttl_lo];

    assign mac_hit = (dmac == mac_addr0) || (dmac == mac_addr1) ||
                     (dmac == mac_addr2) || (dmac == mac_addr3);

    // First failing check wins
    always_comb begin
        if (!mac_hit)
            hdr_verdict = rtr_stream_pkg::verdict_wrong_mac;
        else if (ethertype != rtr_stream_pkg::ethertype_ipv4 || version != 4'd4)
            hdr_verdict = rtr_stream_pkg::verdict_non_ip;
        else if (ttl <= 8'd1)                           // Would expire here
            hdr_verdict = rtr_stream_pkg::verdict_bad_ttl;
        else
            hdr_verdict = rtr_stream_pkg::verdict_pass;
    end

    assign src_port = beat_tuser[rtr_stream_pkg::src_port_pos +: rtr_stream_pkg::port_width];
    // Odd ports are CPU queues
    assign from_cpu = src_port[1] | src_port[3] | src_port[5] | src_port[7];

    // CPU traffic goes to its MAC port, MAC traffic to its CPU port
    always_comb begin
        fwd_tuser = beat_tuser;
        fwd_tuser[rtr_stream_pkg::dst_port_pos +: rtr_stream_pkg::port_width] =
            from_cpu ? (src_port >> 1) : (src_port << 1);
    end

endmodule

`default_nettype wire

//--- design/lookup_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module lookup_fifo #(
    parameter int depth_bits = 2
) (
    input  wire                                  AXI_ACLK,
    input  wire                                  AXI_RESETN,
    input  wire [rtr_stream_pkg::beat_width-1:0] din,
    input  wire                                  wr_en,
    input  wire                                  rd_en,
    output logic [rtr_stream_pkg::beat_width-1:0] dout,
    output logic                                 empty,
    output logic                                 nearly_full
);

    localparam int depth = 1 << depth_bits;

    logic [rtr_stream_pkg::beat_width-1:0] mem [depth];  // Beat storage
    logic [depth_bits-1:0] wr_ptr;
    logic [depth_bits-1:0] rd_ptr;
    logic [depth_bits:0]   count;                        // Occupancy, 0 to depth

    always_ff @(posedge AXI_ACLK) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_RESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;         // Pointers wrap on their own
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // Both or neither
            endcase
        end
    end

    // Fall-through, head is always on the output
    assign dout        = mem[rd_ptr];
    assign empty       = (count == '0);
    assign nearly_full = (count >= (depth_bits + 1)'(depth - 1)); // One slot of slack

    // Upstream must respect nearly_full and the FSM must not pop an empty FIFO
    assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
        !(wr_en && count == (depth_bits + 1)'(depth)));
    assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
        !(rd_en && empty));

endmodule

`default_nettype wire

//--- design/lookup_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module lookup_fsm (
    input  wire                      AXI_ACLK,
    input  wire                      AXI_RESETN,
    input  wire                      fifo_empty,
    input  wire                      fifo_tlast,
    input  rtr_stream_pkg::verdict_t hdr_verdict,
    input  wire                      m_axis_tready,
    output logic                     m_axis_tvalid,
    output logic                     fifo_rd_en,
    output logic                     count_strobe
);

    typedef enum logic [1:0] {
        st_header,                                      // Waiting on a first beat
        st_forward,                                     // Passing the rest of a good packet
        st_discard                                      // Dropping the rest of a bad packet
    } state_t;

    state_t state;
    state_t state_next;
    logic   pass;
    logic   drop_pop;

    assign pass = (hdr_verdict == rtr_stream_pkg::verdict_pass);

    // Output only for good headers and their body beats
    assign m_axis_tvalid = !fifo_empty &&
                           ((state == st_header && pass) || state == st_forward);

    // Bad packets drain one beat per cycle, no back-pressure
    assign drop_pop = !fifo_empty &&
                      ((state == st_header && !pass) || state == st_discard);

    assign fifo_rd_en   = (m_axis_tvalid && m_axis_tready) || drop_pop;
    assign count_strobe = (state == st_header) && fifo_rd_en;   // One per packet

    always_comb begin
        state_next = state;
        case (state)
            st_header: begin
                if (fifo_rd_en && !fifo_tlast)
                    state_next = pass ? st_forward : st_discard;
            end
            st_forward, st_discard: begin
                if (fifo_rd_en && fifo_tlast)
                    state_next = st_header;
            end
            default: state_next = st_header;
        endcase
    end

    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_RESETN)
            state <= st_header;
        else
            state <= state_next;
    end

    // Body beats of a packet are never counted
    assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
        count_strobe && !fifo_tlast |=> !count_strobe);

endmodule

`default_nettype wire

//--- design/lookup_regs.sv
`timescale 1ns/1ps
`default_nettype none

module lookup_regs (
    input  wire                                   AXI_ACLK,
    input  wire                                   AXI_RESETN,
    input  wire                                   reg_wr,
    input  wire                                   reg_rd,
    input  wire [rtr_reg_pkg::reg_addr_width-1:0] reg_addr,
    input  wire [rtr_reg_pkg::reg_width-1:0]      reg_wr_data,
    output logic [rtr_reg_pkg::reg_width-1:0]     reg_rd_data,
    output logic                                  reg_ack,
    input  wire [rtr_reg_pkg::reg_width-1:0]      wrong_mac_count,
    input  wire [rtr_reg_pkg::reg_width-1:0]      non_ip_count,
    input  wire [rtr_reg_pkg::reg_width-1:0]      bad_ttl_count,
    input  wire [rtr_reg_pkg::reg_width-1:0]      forwarded_count,
    output logic [47:0]                           mac_addr0,
    output logic [47:0]                           mac_addr1,
    output logic [47:0]                           mac_addr2,
    output logic [47:0]                           mac_addr3,
    output logic                                  counter_clear
);

    logic [31:0] mac_low  [rtr_stream_pkg::num_mac_ports];
    logic [15:0] mac_high [rtr_stream_pkg::num_mac_ports];  // Upper 16 bits only
    logic        mac_sel;
    logic [1:0]  mac_idx;
    logic        mac_is_high;
    logic [rtr_reg_pkg::reg_addr_width-1:0] mac_off;

    // MAC pairs start at word 1, low word on odd addresses
    assign mac_sel     = (reg_addr >= rtr_reg_pkg::reg_mac0_low) &&
                         (reg_addr <= rtr_reg_pkg::reg_mac3_high);
    assign mac_off     = reg_addr - rtr_reg_pkg::reg_mac0_low;
    assign mac_idx     = mac_off[2:1];
    assign mac_is_high = mac_off[0];

    assign counter_clear = reg_wr && (reg_addr == rtr_reg_pkg::reg_clear);

    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_RESETN) begin
            for (int i = 0; i < rtr_stream_pkg::num_mac_ports; i++) begin
                mac_low[i]  <= '0;
                mac_high[i] <= '0;
            end
        end else if (reg_wr && mac_sel) begin           // Counter writes fall through
            if (mac_is_high)
                mac_high[mac_idx] <= reg_wr_data[15:0];
            else
                mac_low[mac_idx] <= reg_wr_data;
        end
    end

    always_ff @(posedge AXI_ACLK) begin
        if (!AXI_RESETN)
            reg_ack <= 1'b0;
        else
            reg_ack <= reg_wr || reg_rd;                // One cycle after either strobe
    end

    // Registered read mux, valid with the ack
    always_ff @(posedge AXI_ACLK) begin
        if (reg_rd) begin
            if (mac_sel)
                reg_rd_data <= mac_is_high ? {16'h0, mac_high[mac_idx]} : mac_low[mac_idx];
            else
                case (rtr_reg_pkg::reg_addr_t'(reg_addr))
                    rtr_reg_pkg::reg_wrong_mac_count: reg_rd_data <= wrong_mac_count;
                    rtr_reg_pkg::reg_non_ip_count:    reg_rd_data <= non_ip_count;
                    rtr_reg_pkg::reg_bad_ttl_count:   reg_rd_data <= bad_ttl_count;
                    rtr_reg_pkg::reg_forwarded_count: reg_rd_data <= forwarded_count;
                    default:                          reg_rd_data <= '0; // Clear and unmapped
                endcase
        end
    end

    assign mac_addr0 = {mac_high[0], mac_low[0]};
    assign mac_addr1 = {mac_high[1], mac_low[1]};
    assign mac_addr2 = {mac_high[2], mac_low[2]};
    assign mac_addr3 = {mac_high[3], mac_low[3]};

    // Host side issues one access at a time
    assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN) !(reg_wr && reg_rd));

endmodule

`default_nettype wire

//--- design/output_port_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module output_port_lookup (
    input  wire                                    AXI_ACLK,
    input  wire                                    AXI_RESETN,
    // Input stream
    input  wire [rtr_stream_pkg::data_width-1:0]   s_axis_tdata,
    input  wire [rtr_stream_pkg::strb_width-1:0]   s_axis_tstrb,
    input  wire [rtr_stream_pkg::tuser_width-1:0]  s_axis_tuser,
    input  wire                                    s_axis_tvalid,
    input  wire                                    s_axis_tlast,
    output wire                                    s_axis_tready,
    // Output stream
    output wire [rtr_stream_pkg::data_width-1:0]   m_axis_tdata,
    output wire [rtr_stream_pkg::strb_width-1:0]   m_axis_tstrb,
    output wire [rtr_stream_pkg::tuser_width-1:0]  m_axis_tuser,
    output wire                                    m_axis_tvalid,
    output wire                                    m_axis_tlast,
    input  wire                                    m_axis_tready,
    // Register port
    input  wire                                    reg_wr,
    input  wire                                    reg_rd,
    input  wire [rtr_reg_pkg::reg_addr_width-1:0]  reg_addr,
    input  wire [rtr_reg_pkg::reg_width-1:0]      reg_wr_data,
    output wire [rtr_reg_pkg::reg_width-1:0]      reg_rd_data,
    output wire                                    reg_ack
);

    localparam int dw = rtr_stream_pkg::data_width;
    localparam int sw = rtr_stream_pkg::strb_width;
    localparam int uw = rtr_stream_pkg::tuser_width;

    wire [rtr_stream_pkg::beat_width-1:0]  fifo_dout;   // {tlast, tuser, tstrb, tdata}
    wire                                   fifo_empty;
    wire                                   fifo_rd_en;
    wire                                   fifo_nearly_full;
    rtr_stream_pkg::verdict_t              hdr_verdict;
    wire [uw-1:0]                          fwd_tuser;
    wire                                   count_strobe;
    wire                                   counter_clear;
    wire [47:0]                            mac_addr0;
    wire [47:0]                            mac_addr1;
    wire [47:0]                            mac_addr2;
    wire [47:0]                            mac_addr3;
    wire [rtr_reg_pkg::reg_width-1:0]      wrong_mac_count;
    wire [rtr_reg_pkg::reg_width-1:0]      non_ip_count;
    wire [rtr_reg_pkg::reg_width-1:0]      bad_ttl_count;
    wire [rtr_reg_pkg::reg_width-1:0]      forwarded_count;

    assign s_axis_tready = !fifo_nearly_full;

    lookup_fifo #(.depth_bits(2)) u_fifo (
        .AXI_ACLK    (AXI_ACLK),
        .AXI_RESETN  (AXI_RESETN),
        .din         ({s_axis_tlast, s_axis_tuser, s_axis_tstrb, s_axis_tdata}),
        .wr_en       (s_axis_tvalid && s_axis_tready),
        .rd_en       (fifo_rd_en),
        .dout        (fifo_dout),
        .empty       (fifo_empty),
        .nearly_full (fifo_nearly_full)
    );

    header_check u_check (
        .beat_tdata  (fifo_dout[dw-1:0]),
        .beat_tuser  (fifo_dout[dw+sw +: uw]),
        .mac_addr0   (mac_addr0),
        .mac_addr1   (mac_addr1),
        .mac_addr2   (mac_addr2),
        .mac_addr3   (mac_addr3),
        .hdr_verdict (hdr_verdict),
        .fwd_tuser   (fwd_tuser)
    );

    lookup_fsm u_fsm (
        .AXI_ACLK      (AXI_ACLK),
        .AXI_RESETN    (AXI_RESETN),
        .fifo_empty    (fifo_empty),
        .fifo_tlast    (fifo_dout[rtr_stream_pkg::beat_width-1]),
        .hdr_verdict   (hdr_verdict),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .fifo_rd_en    (fifo_rd_en),
        .count_strobe  (count_strobe)
    );

    // Data passes through untouched, only TUSER is rewritten
    assign m_axis_tdata = fifo_dout[dw-1:0];
    assign m_axis_tstrb = fifo_dout[dw +: sw];
    assign m_axis_tuser = fwd_tuser;
    assign m_axis_tlast = fifo_dout[rtr_stream_pkg::beat_width-1];

    event_counters u_counters (
        .AXI_ACLK        (AXI_ACLK),
        .AXI_RESETN      (AXI_RESETN),
        .count_strobe    (count_strobe),
        .hdr_verdict     (hdr_verdict),
        .counter_clear   (counter_clear),
        .wrong_mac_count (wrong_mac_count),
        .non_ip_count    (non_ip_count),
        .bad_ttl_count   (bad_ttl_count),
        .forwarded_count (forwarded_count)
    );

    lookup_regs u_regs (
        .AXI_ACLK        (AXI_ACLK),
        .AXI_RESETN      (AXI_RESETN),
        .reg_wr          (reg_wr),
        .reg_rd          (reg_rd),
        .reg_addr        (reg_addr),
        .reg_wr_data     (reg_wr_data),
        .reg_rd_data     (reg_rd_data),
        .reg_ack         (reg_ack),
        .wrong_mac_count (wrong_mac_count),
        .non_ip_count    (non_ip_count),
        .bad_ttl_count   (bad_ttl_count),
        .forwarded_count (forwarded_count),
        .mac_addr0       (mac_addr0),
        .mac_addr1       (mac_addr1),
        .mac_addr2       (mac_addr2),
        .mac_addr3       (mac_addr3),
        .counter_clear   (counter_clear)
    );

endmodule

`default_nettype wire

//--- design/rtr_reg_pkg.sv
`default_nettype none

package rtr_reg_pkg;

    localparam int reg_width      = 32;
    localparam int reg_addr_width = 4;
    localparam int num_counters   = 4;                    // Wrong MAC, non-IP, bad TTL, forwarded

    // Word address map
    typedef enum logic [reg_addr_width-1:0] {
        reg_clear           = 4'd0,                       // Write-only, zeroes the counters
        reg_mac0_low        = 4'd1,
        reg_mac0_high       = 4'd2,
        reg_mac1_low        = 4'd3,
        reg_mac1_high       = 4'd4,
        reg_mac2_low        = 4'd5,
        reg_mac2_high       = 4'd6,
        reg_mac3_low        = 4'd7,
        reg_mac3_high       = 4'd8,
        reg_wrong_mac_count = 4'd9,                       // Read-only counters from here
        reg_non_ip_count    = 4'd10,
        reg_bad_ttl_count   = 4'd11,
        reg_forwarded_count = 4'd12
    } reg_addr_t;

endpackage

`default_nettype wire

//--- design/rtr_stream_pkg.sv
`default_nettype none

package rtr_stream_pkg;

    // Stream widths
    localparam int data_width  = 256;
    localparam int strb_width  = data_width / 8;         // One strobe bit per byte
    localparam int tuser_width = 128;
    localparam int beat_width  = data_width + strb_width + tuser_width + 1; // Packed FIFO entry

    // One-hot port fields in TUSER
    localparam int port_width   = 8;
    localparam int src_port_pos = 16;
    localparam int dst_port_pos = 24;

    // Header fields on the first beat
    localparam int dmac_hi      = 255;                    // Destination MAC, top 48 bits
    localparam int dmac_lo      = 208;
    localparam int ethertype_hi = 159;
    localparam int ethertype_lo = 144;
    localparam int version_hi   = 143;                    // IP version nibble
    localparam int version_lo   = 140;
    localparam int ttl_hi       = 79;
    localparam int ttl_lo       = 72;

    localparam logic [15:0] ethertype_ipv4 = 16'h0800;

    localparam int num_mac_ports = 4;

    // Header check result, in priority order after pass
    typedef enum logic [1:0] {
        verdict_pass,
        verdict_wrong_mac,
        verdict_non_ip,
        verdict_bad_ttl
    } verdict_t;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the output port lookup testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_output_port_lookup \
    -f vlog.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { echo "Build or simulation error, see sim.log"; exit 1; }
grep -q "TESTBENCH FAILED" sim.log \
    && { echo "Simulation reported a failure"; exit 1; } \
    || echo "Simulation finished without failure"

//--- testbench/tb_output_port_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tb_output_port_lookup;

    localparam int num_packets    = 60;
    localparam int timeout_cycles = num_packets * 4 * 8 + 500;   // Longest packets, slow sink

    logic         AXI_ACLK;
    logic         AXI_RESETN;
    logic [255:0] s_axis_tdata;
    logic [31:0]  s_axis_tstrb;
    logic [127:0] s_axis_tuser;
    logic         s_axis_tvalid;
    logic         s_axis_tlast;
    logic         s_axis_tready;
    logic [255:0] m_axis_tdata;
    logic [31:0]  m_axis_tstrb;
    logic [127:0] m_axis_tuser;
    logic         m_axis_tvalid;
    logic         m_axis_tlast;
    logic         m_axis_tready;
    logic         reg_wr;
    logic         reg_rd;
    logic [3:0]   reg_addr;
    logic [31:0]  reg_wr_data;
    logic [31:0]  reg_rd_data;
    logic         reg_ack;

    logic [47:0]  mac [4];
    logic [255:0] exp_data [$];             // Beats of good packets, in order
    logic [31:0]  exp_strb [$];
    logic [127:0] exp_user [$];
    logic         exp_last [$];
    int           exp_count [4];            // Pass, wrong MAC, non-IP, bad TTL
    int           mismatches;
    int           failures;
    int           cycles;
    logic         rstn_q;

    output_port_lookup u_dut (.*);

    initial begin
        AXI_ACLK = 1'b0;
        forever #4 AXI_ACLK = ~AXI_ACLK;
    end

    // Random back-pressure on the output
    always @(negedge AXI_ACLK) m_axis_tready = ($urandom_range(0, 1) == 1) && AXI_RESETN;

    task automatic compare(input string name, input logic [255:0] got, input logic [255:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Odd bits are CPU queues and map down one, MAC ports map up one
    function automatic logic [7:0] dest_port(input logic [7:0] src);
        return ((src & 8'haa) != 8'h0) ? (src >> 1) : (src << 1);
    endfunction

    // Verdict by check order, 0 is pass
    function automatic int header_class(input logic [255:0] d);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 4; i++) hit |= (d[255:208] == mac[i]);
        if (!hit) return 1;
        if (d[159:144] != 16'h0800 || d[143:140] != 4'd4) return 2;
        if (d[79:72] <= 8'd1) return 3;
        return 0;
    endfunction

    task automatic check_output();
        if (exp_data.size() == 0) begin
            failures++;
            $display("Output beat at %0t with no good packet pending", $time);
            return;
        end
        compare("m_axis_tdata", m_axis_tdata, exp_data.pop_front());
        compare("m_axis_tstrb", 256'(m_axis_tstrb), 256'(exp_strb.pop_front()));
        compare("m_axis_tuser", 256'(m_axis_tuser), 256'(exp_user.pop_front()));
        compare("m_axis_tlast", 256'(m_axis_tlast), 256'(exp_last.pop_front()));
    endtask

    always @(posedge AXI_ACLK) begin
        cycles++;
        rstn_q <= AXI_RESETN;
        if (cycles > 1 && (!AXI_RESETN || !rstn_q))            // Reset and the cycle after
            assert (!m_axis_tvalid && !reg_ack) else begin
                failures++;
                $display("Output valid or register ack high around reset at %0t", $time);
            end
        if (AXI_RESETN && m_axis_tvalid && m_axis_tready) check_output();
        if (cycles >= timeout_cycles) begin
            $display("Run stopped by timeout after %0d cycles, %0d output beats never seen",
                     cycles, exp_data.size());
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
        (reg_wr || reg_rd) |=> reg_ack)
        else begin
            failures++;
            $display("No reg_ack one cycle after a strobe at %0t", $time);
        end
    assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
        !(reg_wr || reg_rd) |=> !reg_ack)
        else begin
            failures++;
            $display("reg_ack without a strobe at %0t", $time);
        end
    // Stalled output must hold
    assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
        m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata) &&
        $stable(m_axis_tstrb) && $stable(m_axis_tuser) && $stable(m_axis_tlast))
        else begin
            failures++;
            $display("Stalled output beat changed at %0t", $time);
        end
    // Input fills up only through an accepted beat
    assert property (@(posedge AXI_ACLK) disable iff (!AXI_RESETN)
        $fell(s_axis_tready) |-> $past(s_axis_tvalid && s_axis_tready))
        else begin
            failures++;
            $display("Input ready dropped without an accepted beat at %0t", $time);
        end

    task automatic reg_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        @(negedge AXI_ACLK);
        reg_wr      = wr;
        reg_rd      = !wr;
        reg_addr    = addr;
        reg_wr_data = wdata;
        @(negedge AXI_ACLK);
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        while (!reg_ack) @(negedge AXI_ACLK);
        rdata = reg_rd_data;
    endtask

    task automatic check_reg(input logic [3:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] got;
        reg_access(1'b0, addr, 32'h0, got);
        compare($sformatf("reg_rd_data %s", name), 256'(got), 256'(exp));
    endtask

    task automatic send_packet(input int kind);
        logic [255:0] data;
        logic [127:0] user;
        logic [7:0]   src;
        int           beats;
        int           cls;
        beats = $urandom_range(1, 4);
        src   = 8'h1 << $urandom_range(0, 7);
        user  = {$urandom, $urandom, $urandom, $urandom};
        user[23:16] = src;
        cls = 0;
        for (int b = 0; b < beats; b++) begin
            for (int w = 0; w < 8; w++) data[w*32 +: 32] = $urandom;
            if (b == 0) begin
                data[255:208] = mac[$urandom_range(0, 3)];
                data[159:144] = 16'h0800;
                data[143:140] = 4'd4;
                data[79:72]   = 8'($urandom_range(2, 255));
                case (kind)
                    1: data[255:208] = 48'({$urandom, $urandom});  // Almost surely a miss
                    2: begin
                        if ($urandom_range(0, 1) == 1) data[159:144] = 16'h86dd;
                        else data[143:140] = 4'd6;
                        data[79:72] = 8'($urandom);                // TTL must not matter
                    end
                    3: data[79:72] = 8'($urandom_range(0, 1));
                    default: ;
                endcase
                cls = header_class(data);
                exp_count[cls]++;
            end
            @(negedge AXI_ACLK);
            s_axis_tvalid = 1'b1;
            s_axis_tdata  = data;
            s_axis_tstrb  = (b == beats - 1) ? $urandom : 32'hffff_ffff;
            s_axis_tuser  = user;
            s_axis_tlast  = (b == beats - 1);
            if (cls == 0) begin
                exp_data.push_back(data);
                exp_strb.push_back(s_axis_tstrb);
                exp_user.push_back({user[127:32], dest_port(src), user[23:0]});
                exp_last.push_back(s_axis_tlast);
            end
            do @(posedge AXI_ACLK); while (!s_axis_tready);
        end
        @(negedge AXI_ACLK);
        s_axis_tvalid = 1'b0;
    endtask

    initial begin
        logic [31:0] rdata;
        int          total;
        void'($urandom(32'h17ab));
        AXI_RESETN    = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tstrb  = '0;
        s_axis_tuser  = '0;
        s_axis_tlast  = 1'b0;
        m_axis_tready = 1'b0;
        reg_wr        = 1'b0;
        reg_rd        = 1'b0;
        reg_addr      = '0;
        reg_wr_data   = '0;
        rstn_q        = 1'b0;
        repeat (5) @(posedge AXI_ACLK);
        @(negedge AXI_ACLK);
        AXI_RESETN = 1'b1;

        for (int i = 0; i < 4; i++) begin
            mac[i] = {16'($urandom), $urandom};
            reg_access(1'b1, 4'(1 + 2 * i), mac[i][31:0], rdata);
            reg_access(1'b1, 4'(2 + 2 * i), {16'($urandom), mac[i][47:32]}, rdata); // Junk on top
        end
        for (int i = 0; i < 4; i++) begin
            check_reg(4'(1 + 2 * i), mac[i][31:0], $sformatf("mac%0d_low", i));
            check_reg(4'(2 + 2 * i), {16'h0, mac[i][47:32]}, $sformatf("mac%0d_high", i));
        end

        for (int p = 0; p < num_packets; p++) send_packet($urandom_range(0, 3));
        while (exp_data.size() != 0) @(negedge AXI_ACLK);
        total = 0;
        while (total != num_packets) begin                  // Until every header is counted
            total = 0;
            for (int a = 9; a <= 12; a++) begin
                reg_access(1'b0, 4'(a), 32'h0, rdata);
                total += int'(rdata);
            end
        end
        check_reg(rtr_reg_pkg::reg_wrong_mac_count, 32'(exp_count[1]), "wrong_mac_count");
        check_reg(rtr_reg_pkg::reg_non_ip_count, 32'(exp_count[2]), "non_ip_count");
        check_reg(rtr_reg_pkg::reg_bad_ttl_count, 32'(exp_count[3]), "bad_ttl_count");
        check_reg(rtr_reg_pkg::reg_forwarded_count, 32'(exp_count[0]), "forwarded_count");
        check_reg(4'd13, 32'h0, "unmapped");

        reg_access(1'b1, rtr_reg_pkg::reg_clear, 32'h0, rdata);
        for (int a = 9; a <= 12; a++) check_reg(4'(a), 32'h0, $sformatf("counter %0d", a));

        $display("Run complete: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
design/rtr_stream_pkg.sv
design/rtr_reg_pkg.sv
design/lookup_fifo.sv
design/header_check.sv
design/lookup_fsm.sv
design/event_counters.sv
design/lookup_regs.sv
design/output_port_lookup.sv
testbench/tb_output_port_lookup.sv
